// File: design/colorOut.sv
`timescale 1ns/1ns

module colorOut
(
	input  logic             clk50M,
	input  logic             clk25M,     // async reset, active high
	input  logic             pixelTick,
	input  vgaPkg::scanPos_t scanMid,    // position from the pattern stage
	input  vgaPkg::rgb_t     pixColor,   // colour for that position
	output logic             hSync,      // active low
	output logic             vSync,      // active low
	output logic             bright,
	output vgaPkg::pixelX_t  hPixel,
	output vgaPkg::pixelY_t  vPixel,
	output vgaPkg::rgb_t     rgb
);
	import vgaPkg::*;

	rgb_t colorBlanked;  // colour with the porches and syncs forced dark

	//////////////////////////////////////////////////////////////////////
	// blanking
	//////////////////////////////////////////////////////////////////////

	// the monitor reads the porches as its black level,
	// so nothing but 0 may reach the DAC outside the window
	assign colorBlanked = scanMid.bright ? pixColor : rgbBlack;

	//////////////////////////////////////////////////////////////////////
	// output register
	//////////////////////////////////////////////////////////////////////

	// syncs and coordinates ride in the same register as the colour,
	// every port changes on the same edge
	always_ff @(posedge clk50M or posedge clk25M)
	begin
		if (clk25M)
		begin
			hSync  <= 1'b1;  // released
			vSync  <= 1'b1;
			bright <= 1'b0;
			hPixel <= '0;
			vPixel <= '0;
			rgb    <= rgbBlack;
		end
		else if (pixelTick)
		begin
			hSync  <= scanMid.hSync;
			vSync  <= scanMid.vSync;
			bright <= scanMid.bright;
			hPixel <= scanMid.x;     // 0 outside the active columns
			vPixel <= scanMid.y;     // 0 outside the active rows
			rgb    <= colorBlanked;
		end
	end

endmodule

// File: design/patternGen.sv
`timescale 1ns/1ns

module patternGen
(
	input  logic                 clk50M,
	input  logic                 clk25M,      // async reset, active high
	input  logic                 pixelTick,
	input  vgaPkg::scanPos_t     scanRaw,     // position from the timing stage
	input  vgaPkg::patternMode_t mode,        // requested pattern
	input  vgaPkg::rgb_t         solidColor,  // colour for solidMode
	output vgaPkg::rgb_t         pixColor,    // unblanked colour
	output vgaPkg::scanPos_t     scanMid      // position matching pixColor
);
	import vgaPkg::*;

	patternMode_t modeLatched;  // mode in effect for this frame
	logic         frameStart;
	logic [2:0]   barIdx;       // bar number from the left
	logic         onEdge;       // outermost row or column
	logic         checkOn;      // white square
	rgb_t         colorNext;

	//////////////////////////////////////////////////////////////////////
	// frame start and mode latch
	//////////////////////////////////////////////////////////////////////

	// counters at 0,0 show up as both syncs low with x and y at 0.
	// that holds for the whole sync corner, so only the first tick counts,
	// the one where the previous sample still had vSync high
	assign frameStart = ~scanRaw.hSync && ~scanRaw.vSync &&
	                    (scanRaw.x == '0) && (scanRaw.y == '0) &&
	                    scanMid.vSync;

	always_ff @(posedge clk50M or posedge clk25M)
	begin
		if (clk25M)
			modeLatched <= barsMode;
		else if (pixelTick && frameStart)
			modeLatched <= mode;  // holds for the rest of the frame
	end

	//////////////////////////////////////////////////////////////////////
	// colour for the incoming position
	//////////////////////////////////////////////////////////////////////

	assign barIdx  = 3'(scanRaw.x / barWidth);              // 0..7
	assign checkOn = scanRaw.x[checkBit] ^ scanRaw.y[checkBit];

	assign onEdge = (scanRaw.x == '0) ||
	                (scanRaw.x == pixelX_t'(hActLen - 1'b1)) ||
	                (scanRaw.y == '0) ||
	                (scanRaw.y == pixelY_t'(vActLen - 1'b1));

	always_comb
	begin
		case (modeLatched)
			barsMode:
			begin
				// each index bit turns one channel fully on
				colorNext = {{4{barIdx[2]}}, {4{barIdx[1]}}, {4{barIdx[0]}}};
			end
			checkerMode:
			begin
				colorNext = checkOn ? rgbWhite : rgbBlack;
			end
			borderMode:
			begin
				colorNext = onEdge ? rgbWhite : rgbBlue;
			end
			default:
			begin
				colorNext = solidColor;  // solidMode, taken fresh each tick
			end
		endcase
	end

	//////////////////////////////////////////////////////////////////////
	// stage register
	//////////////////////////////////////////////////////////////////////

	// colour and position leave together, blanking happens downstream
	always_ff @(posedge clk50M or posedge clk25M)
	begin
		if (clk25M)
		begin
			pixColor <= rgbBlack;
			scanMid  <= scanIdle;
		end
		else if (pixelTick)
		begin
			pixColor <= colorNext;
			scanMid  <= scanRaw;
		end
	end

endmodule

// File: design/vgaPkg.sv
package vgaPkg;

	//////////////////////////////////////////////////////////////////////
	// widths with a meaning
	//////////////////////////////////////////////////////////////////////

	typedef logic [9:0]  scanCount_t;   // horizontal or vertical tick counter
	typedef logic [9:0]  pixelX_t;      // active column 0..639
	typedef logic [8:0]  pixelY_t;      // active row 0..479
	typedef logic [11:0] rgb_t;         // 4 red, 4 green, 4 blue, red on top

	//////////////////////////////////////////////////////////////////////
	// 640x480 scan timing, counted in pixel ticks and lines
	//////////////////////////////////////////////////////////////////////

	localparam scanCount_t hTotal    = 10'd800;  // ticks per line
	localparam scanCount_t hSyncLen  = 10'd96;   // hSync low on ticks 0..95
	localparam scanCount_t hActStart = 10'd144;  // sync plus back porch
	localparam scanCount_t hActLen   = 10'd640;  // visible columns

	localparam scanCount_t vTotal    = 10'd521;  // lines per frame
	localparam scanCount_t vSyncLen  = 10'd2;    // vSync low on lines 0 and 1
	localparam scanCount_t vActStart = 10'd31;
	localparam scanCount_t vActLen   = 10'd480;  // visible rows

	// pattern geometry
	localparam pixelX_t barWidth = 10'd80;  // eight bars across 640 columns
	localparam int      checkBit = 5;       // 32 pixel squares

	// fixed colours
	localparam rgb_t rgbBlack = 12'h000;
	localparam rgb_t rgbWhite = 12'hFFF;
	localparam rgb_t rgbBlue  = 12'h00F;

	//////////////////////////////////////////////////////////////////////
	// pattern select and beam position
	//////////////////////////////////////////////////////////////////////

	typedef enum logic [1:0]
	{
		barsMode    = 2'd0,  // colour bars from bar index bits
		checkerMode = 2'd1,  // black and white squares
		borderMode  = 2'd2,  // white frame around a blue field
		solidMode   = 2'd3   // flat colour from solidColor
	} patternMode_t;

	// one pixel's worth of scan state, passed stage to stage
	typedef struct packed
	{
		logic    hSync;   // active low
		logic    vSync;   // active low
		logic    bright;  // inside the display window
		pixelX_t x;
		pixelY_t y;
	} scanPos_t;

	// idle value with both syncs released
	localparam scanPos_t scanIdle = '{
		hSync:  1'b1,
		vSync:  1'b1,
		bright: 1'b0,
		x:      '0,
		y:      '0
	};

endpackage

// File: design/vgaTiming.sv
`timescale 1ns/1ns

module vgaTiming
(
	input  logic             clk50M,     // system clock
	input  logic             clk25M,     // async reset, active high
	output logic             pixelTick,  // 25 MHz enable, high one cycle in two
	output vgaPkg::scanPos_t scanRaw     // registered beam position
);
	import vgaPkg::*;

	logic       tickDiv;    // one bit divider
	scanCount_t hCount;     // tick within the line
	scanCount_t vCount;     // line within the frame
	logic       hLast;      // last tick of a line
	logic       vLast;      // last line of a frame
	logic       hActive;
	logic       vActive;
	logic       hSyncLow;
	logic       vSyncLow;

	//////////////////////////////////////////////////////////////////////
	// pixel tick
	//////////////////////////////////////////////////////////////////////

	// tickDiv flips every cycle and pixelTick follows it one cycle late,
	// so the first tick lands on the second edge after reset
	always_ff @(posedge clk50M or posedge clk25M)
	begin
		if (clk25M)
		begin
			tickDiv   <= 1'b0;
			pixelTick <= 1'b0;
		end
		else
		begin
			tickDiv   <= ~tickDiv;
			pixelTick <= tickDiv;  // high while tickDiv was 1
		end
	end

	//////////////////////////////////////////////////////////////////////
	// horizontal and vertical counters
	//////////////////////////////////////////////////////////////////////

	assign hLast = (hCount == hTotal - 1'b1);  // tick 799
	assign vLast = (vCount == vTotal - 1'b1);  // line 520

	always_ff @(posedge clk50M or posedge clk25M)
	begin
		if (clk25M)
		begin
			hCount <= '0;
			vCount <= '0;
		end
		else if (pixelTick)
		begin
			if (hLast)
			begin
				hCount <= '0;
				// lines step only at the end of a line
				if (vLast)
					vCount <= '0;  // back to the top of the frame
				else
					vCount <= vCount + 1'b1;
			end
			else
			begin
				hCount <= hCount + 1'b1;
			end
		end
	end

	//////////////////////////////////////////////////////////////////////
	// decode of the current counters
	//////////////////////////////////////////////////////////////////////

	assign hSyncLow = (hCount < hSyncLen);  // ticks 0..95
	assign vSyncLow = (vCount < vSyncLen);  // lines 0..1

	// visible window, start inclusive and end exclusive
	assign hActive = (hCount >= hActStart) && (hCount < hActStart + hActLen);
	assign vActive = (vCount >= vActStart) && (vCount < vActStart + vActLen);

	// position register, one tick behind the counters
	always_ff @(posedge clk50M or posedge clk25M)
	begin
		if (clk25M)
		begin
			scanRaw <= scanIdle;
		end
		else if (pixelTick)
		begin
			scanRaw.hSync  <= ~hSyncLow;
			scanRaw.vSync  <= ~vSyncLow;
			scanRaw.bright <= hActive && vActive;

			// column index inside the window, 0 elsewhere
			if (hActive)
				scanRaw.x <= pixelX_t'(hCount - hActStart);
			else
				scanRaw.x <= '0;

			// row index, same rule
			if (vActive)
				scanRaw.y <= pixelY_t'(vCount - vActStart);
			else
				scanRaw.y <= '0;
		end
	end

endmodule

// File: design/vgaTop.sv
`timescale 1ns/1ns

module vgaTop
(
	input  logic                 clk50M,      // system clock
	input  logic                 clk25M,      // async reset, active high
	input  vgaPkg::patternMode_t mode,        // taken at each frame start
	input  vgaPkg::rgb_t         solidColor,
	output logic                 hSync,
	output logic                 vSync,
	output logic                 bright,
	output vgaPkg::pixelX_t      hPixel,
	output vgaPkg::pixelY_t      vPixel,
	output vgaPkg::rgb_t         rgb
);
	import vgaPkg::*;

	logic     pixelTick;  // shared pixel enable
	scanPos_t scanRaw;    // timing to pattern
	scanPos_t scanMid;    // pattern to output
	rgb_t     pixColor;

	// where the beam is
	vgaTiming timing (
		.clk50M    (clk50M),
		.clk25M    (clk25M),
		.pixelTick (pixelTick),
		.scanRaw   (scanRaw)
	);

	// what colour goes there, one tick later
	patternGen pattern (
		.clk50M     (clk50M),
		.clk25M     (clk25M),
		.pixelTick  (pixelTick),
		.scanRaw    (scanRaw),
		.mode       (mode),
		.solidColor (solidColor),
		.pixColor   (pixColor),
		.scanMid    (scanMid)
	);

	// blanking and the aligned port register
	colorOut result (
		.clk50M    (clk50M),
		.clk25M    (clk25M),
		.pixelTick (pixelTick),
		.scanMid   (scanMid),
		.pixColor  (pixColor),
		.hSync     (hSync),
		.vSync     (vSync),
		.bright    (bright),
		.hPixel    (hPixel),
		.vPixel    (vPixel),
		.rgb       (rgb)
	);

endmodule

// File: files.f
design/vgaPkg.sv
design/vgaTiming.sv
design/patternGen.sv
design/colorOut.sv
design/vgaTop.sv
tb/vgaTb.sv

// File: run.sh
#!/bin/sh
# build the VGA testbench with Verilator, run it, then search the log for the fail message

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir build.log sim.log

verilator --binary --timing --timescale 1ns/1ns -Wno-fatal \
	--top-module vgaTb -f files.f -o vgaSim > build.log 2>&1 \
	&& ./obj_dir/vgaSim > sim.log 2>&1 \
	|| { cat build.log; echo "build or simulation error"; exit 1; }

cat sim.log

grep -q "Simulation finished: FAIL" sim.log \
	&& { echo "result: FAIL"; exit 1; } \
	|| { echo "result: PASS"; exit 0; }

// File: tb/vgaTb.sv
`timescale 1ns/1ns

module vgaTb;
	import vgaPkg::*;

	localparam longint lineCycles  = 2 * longint'(hTotal);           // clk50M cycles per line
	localparam longint frameCycles = lineCycles * longint'(vTotal);
	localparam longint watchdogNs  = 6 * frameCycles * 20;           // six frames at 20 ns

	logic         clk50M;
	logic         clk25M;      // active high reset
	patternMode_t mode;
	rgb_t         solidColor;
	logic         hSync;
	logic         vSync;
	logic         bright;
	pixelX_t      hPixel;
	pixelY_t      vPixel;
	rgb_t         rgb;

	int           seed;
	int           checks [1:5];  // per test
	int           errors [1:5];
	bit           monitorOn;

	// scan tracking seen at the ports
	longint       cyc;
	longint       hFallCyc;
	longint       vFallCyc;
	logic         prevH;
	logic         prevV;
	int           lineBright;    // bright cycles so far in this line
	int           frameLines;    // bright lines so far in this frame
	int           lineNo;        // lines since the last vSync fall
	int           frameNo;       // vSync falling edges seen
	int           patTest;       // test that owns the rgb checks
	patternMode_t curMode;       // mode taken at the last frame start

	vgaTop uut (
		.clk50M     (clk50M),
		.clk25M     (clk25M),
		.mode       (mode),
		.solidColor (solidColor),
		.hSync      (hSync),
		.vSync      (vSync),
		.bright     (bright),
		.hPixel     (hPixel),
		.vPixel     (vPixel),
		.rgb        (rgb)
	);

	initial
	begin
		clk50M = 1'b0;
		forever #10 clk50M = ~clk50M;  // 50 MHz
	end

	initial
	begin
		#(watchdogNs);
		$display("timeout, the run did not get past the last frame");
		$display("Simulation finished: FAIL");
		$finish;
	end

	//////////////////////////////////////////////////////////////////////
	// reference and reporting
	//////////////////////////////////////////////////////////////////////

	// colour a correct source shows at column x, row y
	function automatic rgb_t expectColor(input patternMode_t m, input int x, input int y,
	                                     input logic on, input rgb_t solid);
		int   bar;
		rgb_t c;
		bar = x / 80;  // eight bars of 80 columns
		if (!on)
			c = 12'h000;  // blanked
		else if (m == barsMode)
			c = {((bar & 4) != 0) ? 4'hF : 4'h0, ((bar & 2) != 0) ? 4'hF : 4'h0,
			     ((bar & 1) != 0) ? 4'hF : 4'h0};
		else if (m == checkerMode)
			c = (((x / 32) % 2) != ((y / 32) % 2)) ? 12'hFFF : 12'h000;
		else if (m == borderMode)
			c = (x == 0 || x == 639 || y == 0 || y == 479) ? 12'hFFF : 12'h00F;
		else
			c = solid;
		return c;
	endfunction

	task automatic valueError(input int testNo, input string name, input logic [63:0] got,
	                          input logic [63:0] exp);
		$display("** Error: %s got 0x%0h expected 0x%0h at %0t ns", name, got, exp, $time);
		errors[testNo]++;
	endtask

	task automatic checkIdleOutputs();
		checks[1] += 4;
		if (hSync !== 1'b1)
			valueError(1, "hSync", hSync, 1);
		if (vSync !== 1'b1)
			valueError(1, "vSync", vSync, 1);
		if (bright !== 1'b0)
			valueError(1, "bright", bright, 0);
		if (rgb !== rgbBlack)
			valueError(1, "rgb", rgb, rgbBlack);
	endtask

	task automatic reportTest(input int testNo, input string name);
		$display("test %0d %s done with %0d checks and %0d errors",
		         testNo, name, checks[testNo], errors[testNo]);
	endtask

	//////////////////////////////////////////////////////////////////////
	// port monitor sampled mid cycle
	//////////////////////////////////////////////////////////////////////

	always @(negedge clk50M)
	begin : scanMonitor
		int   xExp;
		int   yExp;
		int   hPos;
		int   vPos;
		bit   brightExp;
		bit   timingOn;
		rgb_t expRgb;
		if (monitorOn)
		begin
			cyc      = cyc + 1;
			timingOn = (frameNo < 3);    // first two full frames

			if (prevH && !hSync)         // line start
			begin
				if (timingOn && hFallCyc > 0)
				begin
					checks[2]++;
					if (cyc - hFallCyc != lineCycles)
						valueError(2, "hSync period", cyc - hFallCyc, lineCycles);
				end
				if (lineBright > 0)
				begin
					if (timingOn)
					begin
						checks[2]++;
						if (lineBright != 2 * hActLen)
							valueError(2, "bright cycles", lineBright, 2 * hActLen);
					end
					frameLines++;
				end
				hFallCyc   = cyc;
				lineBright = 0;
				lineNo++;
			end
			if (!prevH && hSync && timingOn)
			begin
				checks[2]++;
				if (cyc - hFallCyc != 2 * hSyncLen)
					valueError(2, "hSync low time", cyc - hFallCyc, 2 * hSyncLen);
			end

			if (prevV && !vSync)         // frame start
			begin
				if (timingOn && vFallCyc > 0)
				begin
					checks[3] += 2;
					if (cyc - vFallCyc != frameCycles)
						valueError(3, "vSync period", cyc - vFallCyc, frameCycles);
					if (frameLines != vActLen)
						valueError(3, "bright lines", frameLines, vActLen);
				end
				vFallCyc   = cyc;
				frameLines = 0;
				lineNo     = 0;
				frameNo++;
				curMode    = mode;       // holds for the whole frame
				patTest    = (frameNo >= 4) ? 5 : 4;
			end
			if (!prevV && vSync && timingOn)
			begin
				checks[3]++;
				if (cyc - vFallCyc != 2 * lineCycles)
					valueError(3, "vSync low time", cyc - vFallCyc, 2 * lineCycles);
			end

			// beam position counted from the sync edges
			hPos      = int'(cyc - hFallCyc) / 2;  // a pixel tick lasts two cycles
			vPos      = lineNo;
			brightExp = (frameNo >= 1) &&
			            (hPos >= int'(hActStart)) &&
			            (hPos < int'(hActStart + hActLen)) &&
			            (vPos >= int'(vActStart)) &&
			            (vPos < int'(vActStart + vActLen));
			xExp      = hPos - int'(hActStart);
			yExp      = vPos - int'(vActStart);

			if (timingOn && frameNo >= 1)
			begin
				checks[2]++;
				if (bright !== brightExp)
					valueError(2, "bright", bright, brightExp);
				if (brightExp)
				begin
					checks[2]++;
					checks[3]++;
					if (hPixel !== pixelX_t'(xExp))
						valueError(2, "hPixel", hPixel, xExp);
					if (vPixel !== pixelY_t'(yExp))
						valueError(3, "vPixel", vPixel, yExp);
				end
			end
			if (bright)
				lineBright++;

			// every cycle so blanking is covered too
			if (frameNo >= 1)
			begin
				expRgb = expectColor(curMode, xExp, yExp, brightExp, solidColor);
				checks[patTest]++;
				if (rgb !== expRgb)
					valueError(patTest, "rgb", rgb, expRgb);
			end
			prevH = hSync;
			prevV = vSync;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// stimulus
	//////////////////////////////////////////////////////////////////////

	initial
	begin
		int totalChecks;
		int totalErrors;
		seed       = 62;
		clk25M     = 1'b1;
		mode       = barsMode;
		solidColor = rgbBlack;
		monitorOn  = 1'b0;
		cyc        = 0;
		hFallCyc   = 0;
		vFallCyc   = 0;
		prevH      = 1'b1;
		prevV      = 1'b1;
		lineBright = 0;
		frameLines = 0;
		lineNo     = 0;
		frameNo    = 0;
		patTest    = 4;
		curMode    = barsMode;
		foreach (checks[n])
		begin
			checks[n] = 0;
			errors[n] = 0;
		end

		repeat (8)
		begin
			@(negedge clk50M);
			checkIdleOutputs();
		end
		clk25M = 1'b0;  // release on a falling edge
		repeat (3)
		begin
			@(negedge clk50M);
			checkIdleOutputs();  // pipeline still holds idle values
		end
		monitorOn = 1'b1;
		reportTest(1, "reset state");

		// bars, then checker, then border, one frame each
		wait (frameNo == 1);
		repeat (1000) @(negedge clk50M);
		mode = checkerMode;
		wait (frameNo == 2);
		repeat (1000) @(negedge clk50M);
		mode = borderMode;
		wait (frameNo == 3);
		reportTest(2, "horizontal timing");
		reportTest(3, "vertical timing");
		wait (frameNo == 4);
		reportTest(4, "pattern content");

		// switch halfway down and border stays until the next frame
		wait (frameLines == vActLen / 2);
		@(negedge clk50M);
		mode = solidMode;
		while (frameNo < 6)
		begin
			@(negedge hSync);  // new colour in the horizontal blank
			@(negedge clk50M);
			solidColor = rgb_t'($random(seed));
		end
		reportTest(5, "solid colour and frame latched mode");

		totalChecks = 0;
		totalErrors = 0;
		foreach (checks[n])
		begin
			totalChecks += checks[n];
			totalErrors += errors[n];
		end
		$display("%0d checks passed, %0d errors", totalChecks - totalErrors, totalErrors);
		if (totalErrors == 0)
			$display("Simulation finished: PASS");
		else
			$display("Simulation finished: FAIL");
		$finish;
	end

endmodule
